//--- design/boot_pkg.sv
// Shared definitions for the boot loader subsystem.
//   wb_cti_t    Wishbone cycle type identifier
//   biu_func_t  bus interface unit operation
//   default bus, address, line and image sizes
`default_nettype none

package boot_pkg;

    // classic, incrementing burst and end of burst.
    typedef enum logic [2:0] {
        WB_CTI_CLASSIC = 3'b000,
        WB_CTI_INCR    = 3'b010,
        WB_CTI_EOB     = 3'b111
    } wb_cti_t;

    typedef enum logic {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_t;

    // bus word width in bits.
    localparam int WB_DATA_WIDTH_DEF = 32;

    // byte address width.
    localparam int WB_ADDR_WIDTH_DEF = 16;

    // words per cache line.
    localparam int LINE_WORDS_DEF = 4;

    // lines in the boot image.
    localparam int ROM_LINES_DEF = 8;

endpackage

`default_nettype wire

//--- design/boot_rom.sv
// Boot image ROM.
// One full line per entry, loaded from the image file,
// read through an output register.
`timescale 1ns/10ps
`default_nettype none

module boot_rom #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int LINE_WORDS = boot_pkg::LINE_WORDS_DEF,
    parameter int ROM_LINES  = boot_pkg::ROM_LINES_DEF
) (
    input  logic                               i_wb_clk,
    input  logic [$clog2(ROM_LINES)-1:0]       i_rom_addr,
    output logic [DATA_WIDTH*LINE_WORDS-1:0]   o_rom_data
);

    localparam int LINE_BITS = DATA_WIDTH * LINE_WORDS;

    logic [LINE_BITS-1:0] mem [ROM_LINES];

    // word 0 of a line sits in the low bits.
    initial begin
        $readmemh("boot_image.hex", mem);
    end

    always_ff @(posedge i_wb_clk) begin
        o_rom_data <= mem[i_rom_addr];
    end

endmodule

`default_nettype wire

//--- design/boot_ctrl.sv
// Boot sequencer.
// Walks the ROM one line at a time, latches each line and
// hands it to the BIU as a write burst.
// Flags boot done after the last line is written.
`timescale 1ns/10ps
`default_nettype none

module boot_ctrl #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = boot_pkg::WB_ADDR_WIDTH_DEF,
    parameter int LINE_WORDS = boot_pkg::LINE_WORDS_DEF,
    parameter int ROM_LINES  = boot_pkg::ROM_LINES_DEF
) (
    input  logic                               i_wb_clk,
    input  logic                               i_rst_n,
    input  logic [DATA_WIDTH*LINE_WORDS-1:0]   i_rom_data,
    input  logic                               i_biu_done,
    output logic [$clog2(ROM_LINES)-1:0]       o_rom_addr,
    output logic                               o_biu_en,
    output boot_pkg::biu_func_t                o_biu_func,
    output logic [ADDR_WIDTH-1:0]              o_biu_addr,
    output logic [DATA_WIDTH*LINE_WORDS-1:0]   o_biu_data,
    output logic                               o_boot_done
);

    import boot_pkg::*;

    localparam int LINE_BITS  = DATA_WIDTH * LINE_WORDS;
    localparam int LINE_W     = $clog2(ROM_LINES);
    localparam int CNT_W      = LINE_W + 1;
    localparam int LINE_OFF_W = $clog2(LINE_WORDS * DATA_WIDTH / 8);

    typedef enum logic [1:0] {
        ST_RESET = 2'b00,
        ST_LOAD  = 2'b01,
        ST_BUSY  = 2'b10,
        ST_DONE  = 2'b11
    } state_t;

    state_t state_r;
    state_t state_next;
    logic [CNT_W-1:0] line_r;
    logic [CNT_W-1:0] line_next;
    logic last_line;
    logic en_r;
    logic [LINE_BITS-1:0] data_r;

    assign last_line = (line_r == CNT_W'(ROM_LINES - 1));

    always_comb begin
        state_next = state_r;
        line_next = line_r;
        unique case (state_r)
            ST_RESET: state_next = ST_LOAD;
            ST_LOAD:  state_next = ST_BUSY;
            ST_BUSY: begin
                if (i_biu_done) begin
                    state_next = last_line ? ST_DONE : ST_LOAD;
                    line_next = last_line ? line_r : line_r + 1'b1;
                end
            end
            default:  state_next = ST_DONE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            state_r <= ST_RESET;
            line_r <= '0;
            en_r <= 1'b0;
        end else begin
            state_r <= state_next;
            line_r <= line_next;
            en_r <= (state_r == ST_LOAD) | (en_r & ~i_biu_done);
        end
    end

    // rom already sees the next index, so the line is ready in LOAD.
    always_ff @(posedge i_wb_clk) begin
        if (state_r == ST_LOAD) begin
            data_r <= i_rom_data;
        end
    end

    assign o_rom_addr = line_next[LINE_W-1:0];
    assign o_biu_en = en_r;
    assign o_biu_func = BIU_FUNC_WRITE;
    assign o_biu_addr = ADDR_WIDTH'(line_r) << LINE_OFF_W;
    assign o_biu_data = data_r;
    assign o_boot_done = (state_r == ST_DONE);

    a_line_in_range: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        state_r == ST_BUSY |-> line_r <= CNT_W'(ROM_LINES - 1));

endmodule

`default_nettype wire

//--- design/biu_wb_master.sv
// Bus interface unit, Wishbone master side.
// Turns one line request into an incrementing burst of words,
// sending or gathering a word per ack through a line shift register.
`timescale 1ns/10ps
`default_nettype none

module biu_wb_master #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = boot_pkg::WB_ADDR_WIDTH_DEF,
    parameter int LINE_WORDS = boot_pkg::LINE_WORDS_DEF
) (
    input  logic                               i_wb_clk,
    input  logic                               i_rst_n,
    input  logic                               i_biu_en,
    input  boot_pkg::biu_func_t                i_biu_func,
    input  logic [ADDR_WIDTH-1:0]              i_biu_addr,
    input  logic [DATA_WIDTH*LINE_WORDS-1:0]   i_biu_data,
    input  logic                               i_wb_ack,
    input  logic [DATA_WIDTH-1:0]              i_wb_data,
    output logic                               o_biu_done,
    output logic [DATA_WIDTH*LINE_WORDS-1:0]   o_biu_data,
    output logic                               o_wb_cyc,
    output logic                               o_wb_stb,
    output logic                               o_wb_we,
    output boot_pkg::wb_cti_t                  o_wb_cti,
    output logic [ADDR_WIDTH-1:0]              o_wb_addr,
    output logic [DATA_WIDTH-1:0]              o_wb_data
);

    import boot_pkg::*;

    localparam int LINE_BITS = DATA_WIDTH * LINE_WORDS;
    localparam int WORD_W    = $clog2(LINE_WORDS);

    logic cyc_r;
    logic stb_r;
    logic we_r;
    logic [WORD_W-1:0] cnt_r;
    logic [ADDR_WIDTH-1:0] addr_r;
    logic [LINE_BITS-1:0] line_r;
    logic [LINE_BITS-1:0] line_next;
    logic start;
    logic word_ack;
    logic last_word;

    assign start = i_biu_en & ~cyc_r;
    assign word_ack = cyc_r & stb_r & i_wb_ack;
    assign last_word = (cnt_r == WORD_W'(LINE_WORDS - 1));

    // read words enter at the top, write words leave at the bottom.
    assign line_next = {i_wb_data, line_r[LINE_BITS-1:DATA_WIDTH]};

    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            cyc_r <= 1'b0;
            stb_r <= 1'b0;
            we_r <= 1'b0;
            cnt_r <= '0;
        end else if (start) begin
            cyc_r <= 1'b1;
            stb_r <= 1'b1;
            we_r <= (i_biu_func == BIU_FUNC_WRITE);
            cnt_r <= '0;
        end else if (word_ack) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
                cyc_r <= 1'b0;
                stb_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (start) begin
            addr_r <= i_biu_addr;
            line_r <= i_biu_data;
        end else if (word_ack) begin
            addr_r <= addr_r + ADDR_WIDTH'(DATA_WIDTH / 8);
            line_r <= line_next;
        end
    end

    assign o_wb_cyc = cyc_r;
    assign o_wb_stb = stb_r;
    assign o_wb_we = we_r;
    assign o_wb_addr = addr_r;
    assign o_wb_data = line_r[DATA_WIDTH-1:0];
    assign o_wb_cti = !cyc_r ? WB_CTI_CLASSIC : (last_word ? WB_CTI_EOB : WB_CTI_INCR);
    assign o_biu_done = word_ack & last_word;
    assign o_biu_data = line_next;

    a_stb_in_cyc: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        o_wb_stb |-> o_wb_cyc);

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
// Two-master Wishbone arbiter.
// Round-robin on a tie, grant held for the whole cycle,
// ack routed only to the granted master.
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = boot_pkg::WB_ADDR_WIDTH_DEF
) (
    input  logic                    i_wb_clk,
    input  logic                    i_rst_n,
    input  logic                    i_m0_cyc,
    input  logic                    i_m0_stb,
    input  logic                    i_m0_we,
    input  boot_pkg::wb_cti_t       i_m0_cti,
    input  logic [ADDR_WIDTH-1:0]   i_m0_addr,
    input  logic [DATA_WIDTH-1:0]   i_m0_data,
    output logic                    o_m0_ack,
    output logic [DATA_WIDTH-1:0]   o_m0_data,
    input  logic                    i_m1_cyc,
    input  logic                    i_m1_stb,
    input  logic                    i_m1_we,
    input  boot_pkg::wb_cti_t       i_m1_cti,
    input  logic [ADDR_WIDTH-1:0]   i_m1_addr,
    input  logic [DATA_WIDTH-1:0]   i_m1_data,
    output logic                    o_m1_ack,
    output logic [DATA_WIDTH-1:0]   o_m1_data,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic                    o_wb_we,
    output logic [ADDR_WIDTH-1:0]   o_wb_addr,
    output logic [DATA_WIDTH-1:0]   o_wb_data,
    input  logic                    i_wb_ack,
    input  logic [DATA_WIDTH-1:0]   i_wb_data
);

    import boot_pkg::*;

    logic busy_r;
    logic owner_r;
    logic last_r;
    logic busy_next;
    logic owner_next;
    logic owner_cyc;
    logic keep;
    logic gnt_m0;
    logic gnt_m1;

    assign owner_cyc = owner_r ? i_m1_cyc : i_m0_cyc;
    assign keep = busy_r & owner_cyc;

    always_comb begin
        busy_next = 1'b1;
        owner_next = owner_r;
        if (keep) begin
            owner_next = owner_r;
        end else if (i_m0_cyc && i_m1_cyc) begin
            owner_next = ~last_r;
        end else if (i_m0_cyc) begin
            owner_next = 1'b0;
        end else if (i_m1_cyc) begin
            owner_next = 1'b1;
        end else begin
            busy_next = 1'b0;
        end
    end

    // boot master wins the first tie.
    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            owner_r <= 1'b0;
            last_r <= 1'b1;
        end else begin
            busy_r <= busy_next;
            owner_r <= owner_next;
            if (busy_next && !keep) begin
                last_r <= owner_next;
            end
        end
    end

    assign gnt_m0 = busy_r & ~owner_r;
    assign gnt_m1 = busy_r & owner_r;

    assign o_wb_cyc = (gnt_m0 & i_m0_cyc) | (gnt_m1 & i_m1_cyc);
    assign o_wb_stb = (gnt_m0 & i_m0_stb) | (gnt_m1 & i_m1_stb);
    assign o_wb_we = owner_r ? i_m1_we : i_m0_we;
    assign o_wb_addr = owner_r ? i_m1_addr : i_m0_addr;
    assign o_wb_data = owner_r ? i_m1_data : i_m0_data;

    assign o_m0_ack = i_wb_ack & gnt_m0;
    assign o_m1_ack = i_wb_ack & gnt_m1;
    assign o_m0_data = i_wb_data;
    assign o_m1_data = i_wb_data;

    // an ack answers a strobe that master made under its own grant.
    a_m0_ack_granted: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        o_m0_ack |-> $past(gnt_m0 && i_m0_stb));
    a_m1_ack_granted: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        o_m1_ack |-> $past(gnt_m1 && i_m1_stb));

    // a burst is not abandoned before its last word.
    a_m0_burst_open: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        o_m0_ack && i_m0_cti == WB_CTI_INCR |=> i_m0_cyc);
    a_m1_burst_open: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        o_m1_ack && i_m1_cti == WB_CTI_INCR |=> i_m1_cyc);

endmodule

`default_nettype wire

//--- design/wb_sram.sv
// Wishbone slave word memory.
// Word array indexed by the upper address bits,
// ack and read data one cycle after the strobe.
`timescale 1ns/10ps
`default_nettype none

module wb_sram #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = boot_pkg::WB_ADDR_WIDTH_DEF
) (
    input  logic                    i_wb_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [ADDR_WIDTH-1:0]   i_wb_addr,
    input  logic [DATA_WIDTH-1:0]   i_wb_data,
    output logic                    o_wb_ack,
    output logic [DATA_WIDTH-1:0]   o_wb_data
);

    localparam int BYTE_W  = $clog2(DATA_WIDTH / 8);
    localparam int WORD_AW = ADDR_WIDTH - BYTE_W;

    logic [DATA_WIDTH-1:0] mem [2**WORD_AW];
    logic [WORD_AW-1:0] word_addr;
    logic access;
    logic ack_r;

    assign word_addr = i_wb_addr[ADDR_WIDTH-1:BYTE_W];

    // skip the ack cycle so a held strobe is served once.
    assign access = i_wb_cyc & i_wb_stb & ~ack_r;

    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= access;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (access) begin
            if (i_wb_we) begin
                mem[word_addr] <= i_wb_data;
            end
            o_wb_data <= mem[word_addr];
        end
    end

    assign o_wb_ack = ack_r;

endmodule

`default_nettype wire

//--- design/boot_subsys_top.sv
// Boot loader subsystem top level.
// ROM, boot sequencer and BIU on master 0, host port on master 1,
// arbiter and SRAM on the shared Wishbone bus.
`timescale 1ns/10ps
`default_nettype none

module boot_subsys_top #(
    parameter int DATA_WIDTH = boot_pkg::WB_DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = boot_pkg::WB_ADDR_WIDTH_DEF,
    parameter int LINE_WORDS = boot_pkg::LINE_WORDS_DEF,
    parameter int ROM_LINES  = boot_pkg::ROM_LINES_DEF
) (
    input  logic                    i_wb_clk,
    input  logic                    i_rst_n,
    input  logic                    i_host_cyc,
    input  logic                    i_host_stb,
    input  logic                    i_host_we,
    input  logic [ADDR_WIDTH-1:0]   i_host_addr,
    input  logic [DATA_WIDTH-1:0]   i_host_data,
    output logic                    o_host_ack,
    output logic [DATA_WIDTH-1:0]   o_host_data,
    output logic                    o_boot_done
);

    import boot_pkg::*;

    localparam int LINE_BITS = DATA_WIDTH * LINE_WORDS;

    logic [$clog2(ROM_LINES)-1:0] rom_addr;
    logic [LINE_BITS-1:0] rom_data;
    logic biu_en;
    biu_func_t biu_func;
    logic [ADDR_WIDTH-1:0] biu_addr;
    logic [LINE_BITS-1:0] biu_data;
    logic biu_done;

    logic m0_cyc;
    logic m0_stb;
    logic m0_we;
    wb_cti_t m0_cti;
    logic [ADDR_WIDTH-1:0] m0_addr;
    logic [DATA_WIDTH-1:0] m0_wdata;
    logic m0_ack;
    logic [DATA_WIDTH-1:0] m0_rdata;

    logic s_cyc;
    logic s_stb;
    logic s_we;
    logic [ADDR_WIDTH-1:0] s_addr;
    logic [DATA_WIDTH-1:0] s_wdata;
    logic s_ack;
    logic [DATA_WIDTH-1:0] s_rdata;

    boot_rom #(.DATA_WIDTH(DATA_WIDTH), .LINE_WORDS(LINE_WORDS), .ROM_LINES(ROM_LINES)) u_rom (
        .i_wb_clk,
        .i_rom_addr(rom_addr),
        .o_rom_data(rom_data)
    );

    boot_ctrl #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
        .LINE_WORDS(LINE_WORDS), .ROM_LINES(ROM_LINES)
    ) u_ctrl (
        .i_wb_clk, .i_rst_n,
        .i_rom_data(rom_data), .i_biu_done(biu_done),
        .o_rom_addr(rom_addr), .o_biu_en(biu_en), .o_biu_func(biu_func),
        .o_biu_addr(biu_addr), .o_biu_data(biu_data), .o_boot_done
    );

    // read data of the line is not needed on the boot path.
    biu_wb_master #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .LINE_WORDS(LINE_WORDS)) u_biu (
        .i_wb_clk, .i_rst_n,
        .i_biu_en(biu_en), .i_biu_func(biu_func), .i_biu_addr(biu_addr),
        .i_biu_data(biu_data), .o_biu_done(biu_done), .o_biu_data(),
        .i_wb_ack(m0_ack), .i_wb_data(m0_rdata),
        .o_wb_cyc(m0_cyc), .o_wb_stb(m0_stb), .o_wb_we(m0_we), .o_wb_cti(m0_cti),
        .o_wb_addr(m0_addr), .o_wb_data(m0_wdata)
    );

    wb_arbiter #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_arb (
        .i_wb_clk, .i_rst_n,
        .i_m0_cyc(m0_cyc), .i_m0_stb(m0_stb), .i_m0_we(m0_we), .i_m0_cti(m0_cti),
        .i_m0_addr(m0_addr), .i_m0_data(m0_wdata),
        .o_m0_ack(m0_ack), .o_m0_data(m0_rdata),
        .i_m1_cyc(i_host_cyc), .i_m1_stb(i_host_stb), .i_m1_we(i_host_we),
        .i_m1_cti(WB_CTI_CLASSIC), .i_m1_addr(i_host_addr), .i_m1_data(i_host_data),
        .o_m1_ack(o_host_ack), .o_m1_data(o_host_data),
        .o_wb_cyc(s_cyc), .o_wb_stb(s_stb), .o_wb_we(s_we),
        .o_wb_addr(s_addr), .o_wb_data(s_wdata),
        .i_wb_ack(s_ack), .i_wb_data(s_rdata)
    );

    wb_sram #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_sram (
        .i_wb_clk, .i_rst_n,
        .i_wb_cyc(s_cyc), .i_wb_stb(s_stb), .i_wb_we(s_we),
        .i_wb_addr(s_addr), .i_wb_data(s_wdata),
        .o_wb_ack(s_ack), .o_wb_data(s_rdata)
    );

endmodule

`default_nettype wire

//--- bench/boot_subsys_tb.sv
// Testbench for the boot loader subsystem.
//   clock, reset and a host-operation table applied in a loop
//   image model loaded from the boot image file
//   boot done monitor and watchdog
`timescale 1ns/10ps
`default_nettype none

module boot_subsys_tb;

    import boot_pkg::*;

    localparam int DATA_WIDTH   = WB_DATA_WIDTH_DEF;
    localparam int ADDR_WIDTH   = WB_ADDR_WIDTH_DEF;
    localparam int LINE_WORDS   = LINE_WORDS_DEF;
    localparam int ROM_LINES    = ROM_LINES_DEF;
    localparam int LINE_BITS    = DATA_WIDTH * LINE_WORDS;
    localparam int WORD_BYTES   = DATA_WIDTH / 8;
    localparam int IMAGE_WORDS  = ROM_LINES * LINE_WORDS;
    localparam int MODEL_WORDS  = 512;
    localparam int MAX_OPS      = 64;
    localparam int RESET_CYCLES = 10;
    localparam int unsigned SEED = 32'h54917ec9;

    logic clk = 1'b0;
    logic rst_n;
    logic host_cyc;
    logic host_stb;
    logic host_we;
    logic [ADDR_WIDTH-1:0] host_addr;
    logic [DATA_WIDTH-1:0] host_wdata;
    logic host_ack;
    logic [DATA_WIDTH-1:0] host_rdata;
    logic boot_done;

    logic [LINE_BITS-1:0] image_lines [ROM_LINES];
    logic [DATA_WIDTH-1:0] exp_mem [MODEL_WORDS];

    // host-operation table.
    bit op_write [MAX_OPS];
    logic [ADDR_WIDTH-1:0] op_addr [MAX_OPS];
    logic [DATA_WIDTH-1:0] op_wdata [MAX_OPS];
    logic [DATA_WIDTH-1:0] op_exp [MAX_OPS];
    bit op_wait [MAX_OPS];
    int op_count = 0;
    bit ops_ready = 1'b0;

    always #5 clk = ~clk;

    boot_subsys_top u_dut (
        .i_wb_clk(clk),
        .i_rst_n(rst_n),
        .i_host_cyc(host_cyc),
        .i_host_stb(host_stb),
        .i_host_we(host_we),
        .i_host_addr(host_addr),
        .i_host_data(host_wdata),
        .o_host_ack(host_ack),
        .o_host_data(host_rdata),
        .o_boot_done(boot_done)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic bit in_image(input logic [ADDR_WIDTH-1:0] addr);
        return (int'(addr) / WORD_BYTES) < IMAGE_WORDS;
    endfunction

    // boot rewrites image words later, so a pre-boot write there leaves the model alone.
    task automatic add_op(input bit is_write, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] wdata, input bit wait_boot);
        int word_idx;
        word_idx = int'(addr) / WORD_BYTES;
        op_write[op_count] = is_write;
        op_addr[op_count] = addr;
        op_wdata[op_count] = wdata;
        op_wait[op_count] = wait_boot;
        op_exp[op_count] = exp_mem[word_idx];
        if (is_write && (wait_boot || !in_image(addr))) begin
            exp_mem[word_idx] = wdata;
        end
        op_count++;
    endtask

    task automatic build_table();
        for (int i = 0; i < MODEL_WORDS; i++) begin
            exp_mem[i] = '0;
        end
        for (int l = 0; l < ROM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                exp_mem[l * LINE_WORDS + w] = image_lines[l][w * DATA_WIDTH +: DATA_WIDTH];
            end
        end
        // issued while the boot bursts run.
        add_op(1'b0, 16'h0000, '0, 1'b0);
        add_op(1'b1, 16'h0070, 32'hdead0070, 1'b0);
        add_op(1'b0, 16'h0010, '0, 1'b0);
        add_op(1'b1, 16'h0400, 32'h12345678, 1'b0);
        add_op(1'b0, 16'h0400, '0, 1'b0);
        add_op(1'b0, 16'h007c, '0, 1'b0);
        for (int l = 0; l < ROM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                add_op(1'b0, ADDR_WIDTH'((l * LINE_WORDS + w) * WORD_BYTES), '0, 1'b1);
            end
        end
        add_op(1'b1, 16'h0024, 32'h5eed0024, 1'b1);
        add_op(1'b0, 16'h0020, '0, 1'b1);
        add_op(1'b0, 16'h0024, '0, 1'b1);
        add_op(1'b0, 16'h0028, '0, 1'b1);
        add_op(1'b0, 16'h0070, '0, 1'b1);
        add_op(1'b0, 16'h0400, '0, 1'b1);
    endtask

    task automatic wait_boot_done();
        while (!boot_done) begin
            @(posedge clk);
            #1;
        end
    endtask

    // single host transfer, held until ack.
    task automatic host_transfer(input bit is_write, input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [DATA_WIDTH-1:0] wdata,
                                 output logic [DATA_WIDTH-1:0] rdata,
                                 output bit boot_at_ack);
        host_cyc = 1'b1;
        host_stb = 1'b1;
        host_we = is_write;
        host_addr = addr;
        host_wdata = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!host_ack);
        rdata = host_rdata;
        boot_at_ack = boot_done;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we = 1'b0;
    endtask

    // once boot done is seen it must stay high.
    always @(negedge clk) begin
        bit boot_seen;
        if (rst_n === 1'b1) begin
            if (boot_seen) begin
                check_value("o_boot_done", 32'(boot_done), 32'h1);
            end else if (boot_done) begin
                boot_seen = 1'b1;
            end
        end
    end

    initial begin
        int limit;
        wait (ops_ready);
        limit = RESET_CYCLES + IMAGE_WORDS * 6 + 40 * op_count;
        repeat (limit) @(posedge clk);
        abort_run("run timed out waiting for a host ack or for boot done");
    end

    initial begin
        int unsigned seed_val;
        int pre_boot_reads;
        logic [DATA_WIDTH-1:0] rdata;
        bit boot_at_ack;
        seed_val = $urandom(SEED);
        pre_boot_reads = 0;
        rst_n = 1'b0;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        $readmemh("boot_image.hex", image_lines);
        build_table();
        ops_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("o_boot_done", 32'(boot_done), 32'h0);
        check_value("o_host_ack", 32'(host_ack), 32'h0);

        for (int i = 0; i < op_count; i++) begin
            if (op_wait[i]) begin
                wait_boot_done();
            end
            repeat (1 + ($urandom % 4)) @(posedge clk);
            #1;
            host_transfer(op_write[i], op_addr[i], op_wdata[i], rdata, boot_at_ack);
            if (op_write[i]) begin
                if (!op_wait[i] && in_image(op_addr[i]) && boot_at_ack) begin
                    abort_run("host write to an image word finished only after boot done");
                end
            end else begin
                if (!op_wait[i] && !boot_at_ack) begin
                    pre_boot_reads++;
                end
                if (op_wait[i] || !in_image(op_addr[i])) begin
                    check_value($sformatf("o_host_data @0x%h", op_addr[i]), rdata, op_exp[i]);
                end
            end
        end

        repeat (2) @(posedge clk);
        if (pre_boot_reads > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("no host read completed while the boot bursts were running");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- boot_image.hex
// boot image, one 128-bit ROM line per row, lines 0 to 7 from top to bottom.
// columns are word 3, word 2, word 1, word 0 of the line, word 0 on the right.
b0035a70b0025a71b0015a72b0005a73
b0135a60b0125a61b0115a62b0105a63
b0235a50b0225a51b0215a52b0205a53
b0335a40b0325a41b0315a42b0305a43
b0435a30b0425a31b0415a32b0405a33
b0535a20b0525a21b0515a22b0505a23
b0635a10b0625a11b0615a12b0605a13
b0735a00b0725a01b0715a02b0705a03

//--- files.f
design/boot_pkg.sv
design/boot_rom.sv
design/boot_ctrl.sv
design/biu_wb_master.sv
design/wb_arbiter.sv
design/wb_sram.sv
design/boot_subsys_top.sv
bench/boot_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        -f files.f --top-module boot_subsys_tb -o boot_sim \
    && ./obj_dir/boot_sim \
    || exit 1
